// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0 -Wno-fatal
TOP       = ffn_layer_tb
FILELIST  = filelist.f
BUILD_DIR = obj_dir
PASS_MSG  = Testbench passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== filelist.f ====
+incdir+hw
hw/ffn_pkg.sv
hw/weight_bank.sv
hw/sum_tree.sv
hw/matrix_multiply.sv
hw/neuron_activation.sv
hw/ffn_layer.sv
verification/ffn_layer_checker.sv
verification/ffn_layer_tb.sv

// ==== hw/ffn_layer.sv ====
`include "ffn_settings.svh"

module ffn_layer (
  input logic clock,
  input logic arst_n,

  // input vector, element k at slice k
  input logic in_valid,
  input logic [$bits(ffn_pkg::neuron_t)*`FFN_NUM_INPUT_N-1:0] in_neurons,

  // weight write strobe
  input logic weight_we,
  input ffn_pkg::in_idx_t weight_row,
  input ffn_pkg::out_idx_t weight_col,
  input ffn_pkg::weight_t weight_data,

  output logic out_valid,
  output logic [$bits(ffn_pkg::act_t)*`FFN_NUM_OUTPUT_N-1:0] out_neurons
);

  import ffn_pkg::*;

  // the activation stage adds the last cycle
  localparam int unsigned CHAIN = `FFN_LATENCY - 1;

  logic [$bits(weight_t)*`FFN_NUM_INPUT_N*`FFN_NUM_OUTPUT_N-1:0] weight_matrix;
  logic [$bits(acc_t)*`FFN_NUM_OUTPUT_N-1:0] sums;

  logic [CHAIN-1:0] valid_q; // tracks products, tree level 1, tree root
  logic sum_valid;

  weight_bank i_weight_bank (
    .clock         (clock),
    .arst_n        (arst_n),
    .weight_we     (weight_we),
    .weight_row    (weight_row),
    .weight_col    (weight_col),
    .weight_data   (weight_data),
    .weight_matrix (weight_matrix)
  );

  matrix_multiply i_matrix_multiply (
    .clock         (clock),
    .arst_n        (arst_n),
    .in_neurons    (in_neurons),
    .weight_matrix (weight_matrix),
    .sums          (sums)
  );

  // valid runs alongside the datapath, no stall anywhere
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= '0;
    end else begin
      valid_q <= {valid_q[CHAIN-2:0], in_valid};
    end
  end

  assign sum_valid = valid_q[CHAIN-1];

  neuron_activation i_neuron_activation (
    .clock       (clock),
    .arst_n      (arst_n),
    .sum_valid   (sum_valid),
    .sums        (sums),
    .out_valid   (out_valid),
    .out_neurons (out_neurons)
  );

endmodule

// ==== hw/ffn_pkg.sv ====
`include "ffn_settings.svh"

package ffn_pkg;

  // input neuron, two's complement
  typedef logic signed [`FFN_WIDTH-1:0] neuron_t;

  // output neuron after the rectifier, never negative
  typedef logic [`FFN_WIDTH-1:0] act_t;

  typedef logic signed [`FFN_WIDTH-1:0] weight_t;

  // multiplier result and the widened tree sum
  typedef logic signed [`FFN_PROD_WIDTH-1:0] product_t;
  typedef logic signed [`FFN_ACC_WIDTH-1:0] acc_t;

  // weight matrix addressing, row = input neuron, column = output neuron
  typedef logic [$clog2(`FFN_NUM_INPUT_N)-1:0] in_idx_t;
  typedef logic [$clog2(`FFN_NUM_OUTPUT_N)-1:0] out_idx_t;

endpackage

// ==== hw/ffn_settings.svh ====
`ifndef FFN_SETTINGS_SVH
`define FFN_SETTINGS_SVH

// layer size
`define FFN_NUM_INPUT_N 4
`define FFN_NUM_OUTPUT_N 4

// datapath widths
`define FFN_WIDTH 8         // neurons and weights
`define FFN_PROD_WIDTH 16   // one multiplier result
`define FFN_ACC_WIDTH 18    // product width plus log2 of input count

// adder tree depth, log2 of the input count
`define FFN_TREE_LEVELS 2

// fixed point, one in the weight scale is 2**FFN_FRAC_BITS
`define FFN_FRAC_BITS 4

// input sample edge to out_valid
`define FFN_LATENCY 4

`endif

// ==== hw/matrix_multiply.sv ====
`include "ffn_settings.svh"

module matrix_multiply (
  input logic clock,
  input logic arst_n,

  input logic [$bits(ffn_pkg::neuron_t)*`FFN_NUM_INPUT_N-1:0] in_neurons,
  input logic [$bits(ffn_pkg::weight_t)*`FFN_NUM_INPUT_N*`FFN_NUM_OUTPUT_N-1:0] weight_matrix,

  // one tree sum per output neuron, element c at slice c
  output logic [$bits(ffn_pkg::acc_t)*`FFN_NUM_OUTPUT_N-1:0] sums
);

  import ffn_pkg::*;

  localparam int unsigned N = `FFN_NUM_INPUT_N;
  localparam int unsigned M = `FFN_NUM_OUTPUT_N;
  localparam int unsigned NW = $bits(neuron_t);
  localparam int unsigned WW = $bits(weight_t);
  localparam int unsigned PW = $bits(product_t);
  localparam int unsigned AW = $bits(acc_t);

  neuron_t in_n [N];
  weight_t weight [N][M];

  // first pipeline stage, one register per multiplier
  product_t prod_q [N][M];

  // products of one output column gathered across the rows
  logic [N*PW-1:0] col_products [M];

  genvar r, c;
  generate
    for (r = 0; r < N; r++) begin : g_unpack_in
      assign in_n[r] = in_neurons[r*NW +: NW];
    end

    for (r = 0; r < N; r++) begin : g_row
      for (c = 0; c < M; c++) begin : g_col
        assign weight[r][c] = weight_matrix[(r*M+c)*WW +: WW];

        // signed 8 x 8 into 16, cannot overflow
        always_ff @(posedge clock or negedge arst_n) begin
          if (!arst_n) begin
            prod_q[r][c] <= '0;
          end else begin
            prod_q[r][c] <= in_n[r] * weight[r][c];
          end
        end

        assign col_products[c][r*PW +: PW] = prod_q[r][c]; // row r to tree leaf r
      end
    end

    // one reduction tree per output neuron
    for (c = 0; c < M; c++) begin : g_tree
      sum_tree i_sum_tree (
        .clock    (clock),
        .arst_n   (arst_n),
        .products (col_products[c]),
        .sum      (sums[c*AW +: AW])
      );
    end
  endgenerate

endmodule

// ==== hw/neuron_activation.sv ====
`include "ffn_settings.svh"

module neuron_activation (
  input logic clock,
  input logic arst_n,

  input logic sum_valid,
  input logic [$bits(ffn_pkg::acc_t)*`FFN_NUM_OUTPUT_N-1:0] sums,

  output logic out_valid,
  output logic [$bits(ffn_pkg::act_t)*`FFN_NUM_OUTPUT_N-1:0] out_neurons
);

  import ffn_pkg::*;

  localparam int unsigned M = `FFN_NUM_OUTPUT_N;
  localparam int unsigned AW = $bits(acc_t);
  localparam int unsigned OW = $bits(act_t);
  localparam acc_t ACT_MAX = acc_t'((1 << (OW - 1)) - 1); // 127 for 8 bit neurons

  // rectify, drop the fraction bits, clip to the positive neuron range
  function automatic act_t rectify(input acc_t s);
    acc_t scaled;
    scaled = s >>> `FFN_FRAC_BITS;
    if (s < 0) begin
      return '0;
    end else if (scaled > ACT_MAX) begin
      return act_t'(ACT_MAX);
    end
    return act_t'(scaled);
  endfunction

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= sum_valid;
    end
  end

  genvar c;
  generate
    for (c = 0; c < M; c++) begin : g_out
      // only loads on valid sums, holds otherwise
      always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
          out_neurons[c*OW +: OW] <= '0;
        end else if (sum_valid) begin
          out_neurons[c*OW +: OW] <= rectify(acc_t'(sums[c*AW +: AW]));
        end
      end
    end
  endgenerate

endmodule

// ==== hw/sum_tree.sv ====
`include "ffn_settings.svh"

module sum_tree (
  input logic clock,
  input logic arst_n,

  // element k at slice k
  input logic [$bits(ffn_pkg::product_t)*`FFN_NUM_INPUT_N-1:0] products,
  output ffn_pkg::acc_t sum
);

  import ffn_pkg::*;

  localparam int unsigned N = `FFN_NUM_INPUT_N;
  localparam int unsigned PW = $bits(product_t);

  product_t prod [N];

  // sign extended products, the bottom row of the tree
  acc_t leaf [N];

  // registered adders kept as a heap, node i adds children 2i+1 and 2i+2
  // level lv holds nodes (1 << lv) - 1 up to (1 << (lv + 1)) - 2
  acc_t node [N-1];

  genvar k, lv;
  generate
    for (k = 0; k < N; k++) begin : g_leaf
      assign prod[k] = products[k*PW +: PW];
      assign leaf[k] = acc_t'(prod[k]);
    end

    // one register stage per level, each level half the width of the one below
    for (lv = 0; lv < `FFN_TREE_LEVELS; lv++) begin : g_level
      for (k = 0; k < (1 << lv); k++) begin : g_node
        localparam int unsigned IDX = (1 << lv) - 1 + k;
        localparam int unsigned LEFT = 2 * IDX + 1;

        if (lv == `FFN_TREE_LEVELS - 1) begin : g_bottom
          // children are leaves
          always_ff @(posedge clock or negedge arst_n) begin
            if (!arst_n) begin
              node[IDX] <= '0;
            end else begin
              node[IDX] <= leaf[LEFT-(N-1)] + leaf[LEFT+1-(N-1)];
            end
          end
        end else begin : g_inner
          always_ff @(posedge clock or negedge arst_n) begin
            if (!arst_n) begin
              node[IDX] <= '0;
            end else begin
              node[IDX] <= node[LEFT] + node[LEFT+1];
            end
          end
        end
      end
    end
  endgenerate

  assign sum = node[0]; // root of the tree

endmodule

// ==== hw/weight_bank.sv ====
`include "ffn_settings.svh"

module weight_bank (
  input logic clock,
  input logic arst_n,

  input logic weight_we,
  input ffn_pkg::in_idx_t weight_row,
  input ffn_pkg::out_idx_t weight_col,
  input ffn_pkg::weight_t weight_data,

  // element (r, c) sits at slice r * NUM_OUTPUT_N + c
  output logic [$bits(ffn_pkg::weight_t)*`FFN_NUM_INPUT_N*`FFN_NUM_OUTPUT_N-1:0] weight_matrix
);

  import ffn_pkg::*;

  localparam int unsigned W = $bits(weight_t);

  weight_t mem [`FFN_NUM_INPUT_N][`FFN_NUM_OUTPUT_N];

  // one element per strobe
  // a vector sampled on the write edge still sees the old value
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      for (int r = 0; r < `FFN_NUM_INPUT_N; r++) begin
        for (int c = 0; c < `FFN_NUM_OUTPUT_N; c++) begin
          mem[r][c] <= '0;
        end
      end
    end else if (weight_we) begin
      mem[weight_row][weight_col] <= weight_data;
    end
  end

  // whole matrix presented in parallel to the multiplier grid
  genvar r, c;
  generate
    for (r = 0; r < `FFN_NUM_INPUT_N; r++) begin : g_row
      for (c = 0; c < `FFN_NUM_OUTPUT_N; c++) begin : g_col
        assign weight_matrix[(r*`FFN_NUM_OUTPUT_N+c)*W +: W] = mem[r][c];
      end
    end
  endgenerate

endmodule

// ==== verification/ffn_layer_checker.sv ====
`include "ffn_settings.svh"

module ffn_layer_checker (
  input logic clock,
  input logic arst_n,
  input logic in_valid,
  input logic out_valid,
  input logic [$bits(ffn_pkg::act_t)*`FFN_NUM_OUTPUT_N-1:0] out_neurons
);

  import ffn_pkg::*;

  localparam int unsigned M = `FFN_NUM_OUTPUT_N;
  localparam int unsigned OW = $bits(act_t);
  localparam int ACT_MAX = 127;

  logic over_range; // some output neuron above the rectifier limit

  always_comb begin
    over_range = 1'b0;
    for (int c = 0; c < M; c++) begin
      if (int'(out_neurons[c*OW +: OW]) > ACT_MAX) begin
        over_range = 1'b1;
      end
    end
  end

  // fixed latency, no stalls
  a_latency: assert property (@(posedge clock) disable iff (!arst_n)
    out_valid == $past(in_valid, `FFN_LATENCY))
    else $error("out_valid is not in_valid delayed by the layer latency");

  a_range: assert property (@(posedge clock) disable iff (!arst_n)
    out_valid |-> !over_range)
    else $error("output neuron above the saturation limit");

  a_known: assert property (@(posedge clock) disable iff (!arst_n)
    !$isunknown(out_valid))
    else $error("out_valid unknown after reset");

endmodule

bind ffn_layer ffn_layer_checker i_ffn_layer_checker (
  .clock       (clock),
  .arst_n      (arst_n),
  .in_valid    (in_valid),
  .out_valid   (out_valid),
  .out_neurons (out_neurons)
);

// ==== verification/ffn_layer_tb.sv ====
`include "ffn_settings.svh"

module ffn_layer_tb;

  import ffn_pkg::*;

  localparam int unsigned N = `FFN_NUM_INPUT_N;
  localparam int unsigned M = `FFN_NUM_OUTPUT_N;
  localparam int unsigned NW = $bits(neuron_t);
  localparam int unsigned OW = $bits(act_t);
  localparam int ACT_MAX = 127;
  localparam int DRAIN_TIMEOUT = 50; // cycles

  logic clock;
  logic arst_n;
  logic in_valid;
  logic [NW*N-1:0] in_neurons;
  logic weight_we;
  in_idx_t weight_row;
  out_idx_t weight_col;
  weight_t weight_data;
  logic out_valid;
  logic [OW*M-1:0] out_neurons;

  integer seed = 63;
  int errors = 0;
  int checks = 0;
  int accepted = 0;
  int results = 0;
  string test_name = "none";

  int model_w [N][M];              // reference copy of the weight bank
  logic [OW*M-1:0] expected_q [$]; // one entry per accepted vector, in order
  logic [OW*M-1:0] exp_vec;

  ffn_layer i_dut (
    .clock       (clock),
    .arst_n      (arst_n),
    .in_valid    (in_valid),
    .in_neurons  (in_neurons),
    .weight_we   (weight_we),
    .weight_row  (weight_row),
    .weight_col  (weight_col),
    .weight_data (weight_data),
    .out_valid   (out_valid),
    .out_neurons (out_neurons)
  );

  always #20 clock = ~clock;

  // weighted sum, rectify, drop fraction bits, saturate
  function automatic logic [OW*M-1:0] model_outputs(input logic [NW*N-1:0] vec);
    int sum;
    int scaled;
    logic [OW*M-1:0] res;
    res = '0;
    for (int c = 0; c < M; c++) begin
      sum = 0;
      for (int r = 0; r < N; r++) begin
        sum += $signed(vec[r*NW +: NW]) * model_w[r][c];
      end
      if (sum < 0) begin
        scaled = 0;
      end else begin
        scaled = sum >>> `FFN_FRAC_BITS;
        if (scaled > ACT_MAX) scaled = ACT_MAX;
      end
      res[c*OW +: OW] = scaled[OW-1:0];
    end
    return res;
  endfunction

  // one clock of stimulus; the vector sees the weights from before this write
  task automatic drive_cycle(input logic valid, input logic [NW*N-1:0] vec, input logic we,
                             input in_idx_t row, input out_idx_t col, input weight_t data);
    @(negedge clock);
    in_valid = valid;
    in_neurons = vec;
    weight_we = we;
    weight_row = row;
    weight_col = col;
    weight_data = data;
    if (valid) begin
      expected_q.push_back(model_outputs(vec));
      accepted++;
    end
    if (we) model_w[row][col] = $signed(data);
  endtask

  task automatic write_weight(input int row, input int col, input weight_t data);
    drive_cycle(1'b0, '0, 1'b1, in_idx_t'(row), out_idx_t'(col), data);
  endtask

  task automatic start_test(input string name);
    test_name = name;
    accepted = 0;
    results = 0;
  endtask

  // idle the inputs, wait for every result, then compare counts
  task automatic drain_results();
    int waited;
    waited = 0;
    drive_cycle(1'b0, '0, 1'b0, '0, '0, '0);
    while (expected_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
      @(negedge clock);
      waited++;
    end
    if (expected_q.size() != 0) begin
      $display("timeout in %s: %0d results never arrived", test_name, expected_q.size());
      errors++;
      expected_q.delete();
    end
    if (results != accepted) begin
      $display("ERR %s result count expected %0d actual %0d", test_name, accepted, results);
      errors++;
    end
  endtask

  // scoreboard sampling at the falling edge where outputs are stable
  always @(negedge clock) begin
    if (arst_n && out_valid) begin
      results++;
      if (expected_q.size() == 0) begin
        $display("out_valid high in %s with no vector in flight", test_name);
        errors++;
      end else begin
        exp_vec = expected_q.pop_front();
        for (int c = 0; c < M; c++) begin
          checks++;
          if (out_neurons[c*OW +: OW] !== exp_vec[c*OW +: OW]) begin
            $display("ERR %s neuron %0d expected %0d actual %0d", test_name, c,
                     exp_vec[c*OW +: OW], out_neurons[c*OW +: OW]);
            errors++;
          end
        end
      end
    end else if (arst_n) begin
      // between results the outputs keep the last expected vector
      if (out_neurons !== exp_vec) begin
        $display("ERR %s held outputs expected %0h actual %0h", test_name, exp_vec,
                 out_neurons);
        errors++;
      end
    end
  end

  initial begin
    clock = 1'b0;
    arst_n = 1'b0;
    in_valid = 1'b0;
    in_neurons = '0;
    weight_we = 1'b0;
    weight_row = '0;
    weight_col = '0;
    weight_data = '0;
    exp_vec = '0; // outputs reset to zero
    for (int r = 0; r < N; r++) begin
      for (int c = 0; c < M; c++) model_w[r][c] = 0;
    end
    repeat (16) @(posedge clock);
    @(negedge clock);
    arst_n = 1'b1;

    start_test("reset_zero"); // bank is still all zero
    repeat (8) drive_cycle(1'b1, $random(seed), 1'b0, '0, '0, '0);
    drain_results();

    start_test("identity_weights");
    for (int r = 0; r < N; r++) begin
      for (int c = 0; c < M; c++) write_weight(r, c, (r == c) ? 8'sd16 : 8'sd0);
    end
    repeat (8) drive_cycle(1'b1, $random(seed) & 32'h7f7f7f7f, 1'b0, '0, '0, '0);
    repeat (8) drive_cycle(1'b1, $random(seed) | 32'h80808080, 1'b0, '0, '0, '0);
    drain_results();

    start_test("random_stream");
    for (int i = 0; i < 48; i++) begin
      drive_cycle(1'b1, $random(seed), 1'($random(seed)), in_idx_t'($random(seed)),
                  out_idx_t'($random(seed)), weight_t'($random(seed)));
    end
    drain_results();

    start_test("saturation");
    for (int r = 0; r < N; r++) begin
      for (int c = 0; c < M; c++) write_weight(r, c, 8'sd127);
    end
    repeat (4) drive_cycle(1'b1, 32'h7f7f7f7f, 1'b0, '0, '0, '0);
    for (int r = 0; r < N; r++) begin
      for (int c = 0; c < M; c++) write_weight(r, c, -8'sd128);
    end
    repeat (4) drive_cycle(1'b1, ($random(seed) & 32'h7f7f7f7f) | 32'h01010101, 1'b0,
                           '0, '0, '0);
    drain_results();

    start_test("weight_update_midstream");
    // a fresh matrix goes in one element per cycle while vectors stream
    for (int i = 0; i < 24; i++) begin
      if (i >= 4 && i < 4 + N * M) begin
        drive_cycle(1'b1, $random(seed), 1'b1, in_idx_t'((i - 4) / M),
                    out_idx_t'((i - 4) % M), weight_t'($random(seed)));
      end else begin
        drive_cycle(1'b1, $random(seed), 1'b0, '0, '0, '0);
      end
    end
    drain_results();

    start_test("gaps");
    for (int i = 0; i < 60; i++) begin
      drive_cycle(1'($random(seed)), $random(seed), 1'b0, '0, '0, '0);
    end
    drain_results();

    $display("errors: %0d, neuron checks: %0d", errors, checks);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule
